/* source/sdma_pkg.sv */
package sdma_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////////////////////////////////////////////////

    // System byte address
    typedef logic [31:0] addr_t;

    // One FIFO word, also one AXI beat
    typedef logic [31:0] word_t;

    // Number of 512-byte blocks
    typedef logic [15:0] block_count_t;

    // SDMA buffer boundary select
    typedef logic [2:0] boundary_code_t;

    // Words known to be in the FIFO
    typedef logic [11:0] credit_t;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer states and channel bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        IDLE,
        WAIT_CREDIT,
        BURST,
        BLOCK_CHECK,
        BOUNDARY_WAIT
    } sdma_state_e;

    // AXI write address channel
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } aw_chan_t;

    // AXI write data channel
    typedef struct packed {
        logic  valid;
        word_t data;
        logic  last;
    } w_chan_t;

    // Sticky interrupt flags
    typedef struct packed {
        logic complete;
        logic boundary;
    } irq_t;

    // 512-byte block in 32-bit words
    localparam int BLOCK_WORDS = 128;
    localparam int BEAT_BYTES  = 4;

endpackage

/* source/sdma_sequencer.sv */
`timescale 1ns/1ps

module sdma_sequencer (
    input  logic             clock,
    input  logic             reset,
    input  logic             start,
    input  logic             sys_addr_changed,
    input  logic             abort,
    input  logic             credits_ready,
    input  logic             burst_done,
    input  logic             block_end,
    input  logic             transfer_end,
    input  logic             window_end,
    input  logic             irq_clear,
    output logic             burst_go,
    output logic             counters_clear,
    output logic             window_clear,
    output logic             addr_load_start,
    output logic             addr_load_new,
    output sdma_pkg::irq_t   irq,
    output logic             busy
);

    sdma_pkg::sdma_state_e state;
    sdma_pkg::sdma_state_e state_next;
    logic                  set_complete;
    logic                  set_boundary;

    ////////////////////////////////////////////////////////////////////////////
    // Next state and strobes
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_next      = state;
        burst_go        = 1'b0;
        counters_clear  = 1'b0;
        window_clear    = 1'b0;
        addr_load_start = 1'b0;
        addr_load_new   = 1'b0;
        set_complete    = 1'b0;
        set_boundary    = 1'b0;
        case (state)
            sdma_pkg::IDLE: begin
                if (start) begin
                    counters_clear  = 1'b1;
                    addr_load_start = 1'b1;
                    state_next      = sdma_pkg::WAIT_CREDIT;
                end
            end
            sdma_pkg::WAIT_CREDIT: begin
                // A full burst of words must already sit in the FIFO
                if (credits_ready) begin
                    burst_go   = 1'b1;
                    state_next = sdma_pkg::BURST;
                end
            end
            sdma_pkg::BURST: begin
                if (burst_done) begin
                    state_next = sdma_pkg::BLOCK_CHECK;
                end
            end
            sdma_pkg::BLOCK_CHECK: begin
                // Tracker flags are valid here one cycle after burst_done
                if (block_end && transfer_end) begin
                    set_complete = 1'b1;
                    state_next   = sdma_pkg::IDLE;
                end else if (block_end && window_end) begin
                    set_boundary = 1'b1;
                    state_next   = sdma_pkg::BOUNDARY_WAIT;
                end else begin
                    state_next = sdma_pkg::WAIT_CREDIT;
                end
            end
            sdma_pkg::BOUNDARY_WAIT: begin
                if (sys_addr_changed) begin
                    window_clear  = 1'b1;
                    addr_load_new = 1'b1;
                    state_next    = sdma_pkg::WAIT_CREDIT;
                end
            end
            default: state_next = sdma_pkg::IDLE;
        endcase
        // Abort wins over everything
        if (abort) begin
            state_next      = sdma_pkg::IDLE;
            burst_go        = 1'b0;
            counters_clear  = 1'b0;
            window_clear    = 1'b0;
            addr_load_start = 1'b0;
            addr_load_new   = 1'b0;
            set_complete    = 1'b0;
            set_boundary    = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= sdma_pkg::IDLE;
            irq   <= '0;
        end else begin
            state <= state_next;
            if (irq_clear) begin
                irq <= '0;
            end
            // Set has priority over clear
            if (set_complete) begin
                irq.complete <= 1'b1;
            end
            if (set_boundary) begin
                irq.boundary <= 1'b1;
            end
        end
    end

    assign busy = (state != sdma_pkg::IDLE);

    // Writer completion only arrives while a burst is in flight
    a_done_in_burst: assert property (@(posedge clock) disable iff (!reset)
        burst_done |-> (state == sdma_pkg::BURST));

endmodule

/* source/block_tracker.sv */
`timescale 1ns/1ps

module block_tracker #(
    parameter int BURST_BEATS = 16
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     counters_clear,
    input  logic                     window_clear,
    input  logic                     burst_done,
    input  sdma_pkg::block_count_t   block_count,
    input  sdma_pkg::boundary_code_t buf_boundary,
    output logic                     block_end,
    output logic                     transfer_end,
    output logic                     window_end
);

    localparam int WORD_W = $clog2(sdma_pkg::BLOCK_WORDS);

    logic [WORD_W-1:0]      word_count;
    logic                   last_burst;
    sdma_pkg::block_count_t total_blocks;
    sdma_pkg::block_count_t window_blocks;
    sdma_pkg::block_count_t count_limit;
    sdma_pkg::block_count_t window_size;

    // Boundary code n means 8 << n blocks per window
    function automatic sdma_pkg::block_count_t decode_window(sdma_pkg::boundary_code_t code);
        return sdma_pkg::block_count_t'(8) << code;
    endfunction

    assign last_burst = (word_count == WORD_W'(sdma_pkg::BLOCK_WORDS - BURST_BEATS));

    always_ff @(posedge clock) begin
        if (!reset) begin
            word_count    <= '0;
            block_end     <= 1'b0;
            total_blocks  <= '0;
            window_blocks <= '0;
            count_limit   <= '0;
            window_size   <= '0;
        end else if (counters_clear) begin
            word_count    <= '0;
            block_end     <= 1'b0;
            total_blocks  <= '0;
            window_blocks <= '0;
            count_limit   <= block_count;
            window_size   <= decode_window(buf_boundary);
        end else begin
            block_end <= burst_done && last_burst;
            if (window_clear) begin
                window_blocks <= '0;
            end
            if (burst_done) begin
                if (last_burst) begin
                    word_count    <= '0;
                    total_blocks  <= total_blocks + 1'b1;
                    window_blocks <= window_blocks + 1'b1;
                end else begin
                    word_count <= word_count + WORD_W'(BURST_BEATS);
                end
            end
        end
    end

    // Only read in BLOCK_CHECK, together with block_end
    assign transfer_end = (total_blocks == count_limit);
    assign window_end   = (window_blocks == window_size);

    a_total_in_range: assert property (@(posedge clock) disable iff (!reset)
        total_blocks <= count_limit);

endmodule

/* source/credit_counter.sv */
`timescale 1ns/1ps

module credit_counter #(
    parameter int BURST_BEATS = 16
) (
    input  logic clock,
    input  logic reset,
    input  logic clear,
    input  logic credit,
    input  logic beat_taken,
    output logic credits_ready
);

    sdma_pkg::credit_t count;

    ////////////////////////////////////////////////////////////////////////////
    // One credit per word written, one spent per word popped
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
        end else if (clear) begin
            // Keep a credit that lands on the start cycle
            count <= sdma_pkg::credit_t'(credit);
        end else begin
            count <= count + sdma_pkg::credit_t'(credit)
                           - sdma_pkg::credit_t'(beat_taken);
        end
    end

    assign credits_ready = (count >= sdma_pkg::credit_t'(BURST_BEATS));

    // The writer never pops a word the serializer has not reported
    a_no_underflow: assert property (@(posedge clock) disable iff (!reset)
        beat_taken && !clear |-> count != '0);

endmodule

/* source/burst_writer.sv */
`timescale 1ns/1ps

module burst_writer #(
    parameter int BURST_BEATS = 16
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 abort,
    input  logic                 burst_go,
    input  logic                 addr_load_start,
    input  logic                 addr_load_new,
    input  sdma_pkg::addr_t      start_addr,
    input  sdma_pkg::addr_t      new_addr,
    input  sdma_pkg::word_t      fifo_data,
    input  logic                 aw_ready,
    input  logic                 w_ready,
    output sdma_pkg::aw_chan_t   aw,
    output sdma_pkg::w_chan_t    w,
    output logic                 fifo_read,
    output logic                 burst_done
);

    localparam int BEAT_W = $clog2(BURST_BEATS + 1);
    localparam sdma_pkg::addr_t ADDR_STEP =
        sdma_pkg::addr_t'(BURST_BEATS * sdma_pkg::BEAT_BYTES);

    sdma_pkg::addr_t   burst_addr;
    logic              aw_valid;
    logic              w_valid;
    logic [BEAT_W-1:0] beat;
    logic              last_beat;
    logic              aw_handshake;
    logic              w_handshake;

    assign aw_handshake = aw_valid && aw_ready;
    assign w_handshake  = w_valid && w_ready;
    assign last_beat    = (beat == BEAT_W'(BURST_BEATS - 1));

    ////////////////////////////////////////////////////////////////////////////
    // Address and data phases
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            aw_valid   <= 1'b0;
            w_valid    <= 1'b0;
            beat       <= '0;
            burst_done <= 1'b0;
        end else begin
            burst_done <= 1'b0;
            if (abort) begin
                aw_valid <= 1'b0;
                w_valid  <= 1'b0;
                beat     <= '0;
            end else begin
                if (burst_go) begin
                    aw_valid <= 1'b1;
                end else if (aw_handshake) begin
                    aw_valid <= 1'b0;
                    w_valid  <= 1'b1;
                    beat     <= '0;
                end
                if (w_handshake) begin
                    if (last_beat) begin
                        w_valid    <= 1'b0;
                        burst_done <= 1'b1;
                    end else begin
                        beat <= beat + 1'b1;
                    end
                end
            end
        end
    end

    // Next burst address, 64 bytes on per accepted address
    always_ff @(posedge clock) begin
        if (addr_load_start) begin
            burst_addr <= start_addr;
        end else if (addr_load_new) begin
            burst_addr <= new_addr;
        end else if (aw_handshake) begin
            burst_addr <= burst_addr + ADDR_STEP;
        end
    end

    // FIFO head is the beat payload, popped on acceptance
    assign aw        = '{valid: aw_valid, addr: burst_addr};
    assign w         = '{valid: w_valid, data: fifo_data, last: w_valid && last_beat};
    assign fifo_read = w_handshake;

    a_aw_stable: assert property (@(posedge clock) disable iff (!reset)
        aw.valid && !aw_ready && !abort |=> aw.valid && $stable(aw.addr));

    // Also holds the FIFO to its head while no pop happens
    a_w_stable: assert property (@(posedge clock) disable iff (!reset)
        w.valid && !w_ready && !abort |=> w.valid && $stable(w.data) && $stable(w.last));

endmodule

/* source/sdma_engine.sv */
`timescale 1ns/1ps

module sdma_engine #(
    parameter int BURST_BEATS = 16
) (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     start,
    input  sdma_pkg::addr_t          start_addr,
    input  sdma_pkg::block_count_t   block_count,
    input  sdma_pkg::boundary_code_t buf_boundary,
    input  logic                     sys_addr_changed,
    input  sdma_pkg::addr_t          new_addr,
    input  logic                     abort,
    input  logic                     irq_clear,
    input  logic                     credit,
    input  sdma_pkg::word_t          fifo_data,
    output logic                     fifo_read,
    output sdma_pkg::aw_chan_t       aw,
    input  logic                     aw_ready,
    output sdma_pkg::w_chan_t        w,
    input  logic                     w_ready,
    output sdma_pkg::irq_t           irq,
    output logic                     busy
);

    logic burst_go;
    logic burst_done;
    logic counters_clear;
    logic window_clear;
    logic addr_load_start;
    logic addr_load_new;
    logic credits_ready;
    logic block_end;
    logic transfer_end;
    logic window_end;

    sdma_sequencer u_sequencer (
        .clock            (clock),
        .reset            (reset),
        .start            (start),
        .sys_addr_changed (sys_addr_changed),
        .abort            (abort),
        .credits_ready    (credits_ready),
        .burst_done       (burst_done),
        .block_end        (block_end),
        .transfer_end     (transfer_end),
        .window_end       (window_end),
        .irq_clear        (irq_clear),
        .burst_go         (burst_go),
        .counters_clear   (counters_clear),
        .window_clear     (window_clear),
        .addr_load_start  (addr_load_start),
        .addr_load_new    (addr_load_new),
        .irq              (irq),
        .busy             (busy)
    );

    block_tracker #(.BURST_BEATS(BURST_BEATS)) u_tracker (
        .clock          (clock),
        .reset          (reset),
        .counters_clear (counters_clear),
        .window_clear   (window_clear),
        .burst_done     (burst_done),
        .block_count    (block_count),
        .buf_boundary   (buf_boundary),
        .block_end      (block_end),
        .transfer_end   (transfer_end),
        .window_end     (window_end)
    );

    // Every popped word is a spent credit
    credit_counter #(.BURST_BEATS(BURST_BEATS)) u_credits (
        .clock         (clock),
        .reset         (reset),
        .clear         (counters_clear),
        .credit        (credit),
        .beat_taken    (fifo_read),
        .credits_ready (credits_ready)
    );

    burst_writer #(.BURST_BEATS(BURST_BEATS)) u_writer (
        .clock           (clock),
        .reset           (reset),
        .abort           (abort),
        .burst_go        (burst_go),
        .addr_load_start (addr_load_start),
        .addr_load_new   (addr_load_new),
        .start_addr      (start_addr),
        .new_addr        (new_addr),
        .fifo_data       (fifo_data),
        .aw_ready        (aw_ready),
        .w_ready         (w_ready),
        .aw              (aw),
        .w               (w),
        .fifo_read       (fifo_read),
        .burst_done      (burst_done)
    );

endmodule

/* verif/sdma_engine_tb.sv */
`timescale 1ns/1ps

module sdma_engine_tb;

    localparam int BURST_BEATS = 16;
    localparam int FIFO_CAP    = 48;
    // 3 + 12 blocks, up to 2 aborted, 1 after the restart
    localparam int TOTAL_BEATS = 18 * sdma_pkg::BLOCK_WORDS;
    localparam int CYCLE_LIMIT = 4 * (TOTAL_BEATS * 4 + 200);

    logic                     clock = 1'b0;
    logic                     reset;
    logic                     start;
    sdma_pkg::addr_t          start_addr;
    sdma_pkg::block_count_t   block_count;
    sdma_pkg::boundary_code_t buf_boundary;
    logic                     sys_addr_changed;
    sdma_pkg::addr_t          new_addr;
    logic                     abort;
    logic                     irq_clear;
    logic                     credit   = 1'b0;
    logic                     aw_ready = 1'b0;
    logic                     w_ready  = 1'b0;
    sdma_pkg::word_t          fifo_data;
    logic                     fifo_read;
    sdma_pkg::aw_chan_t       aw;
    sdma_pkg::w_chan_t        w;
    sdma_pkg::irq_t           irq;
    logic                     busy;

    logic [31:0]     rnd_state    = 32'h26c27740;
    int              errors       = 0;
    int              cycles       = 0;
    int              wr_ptr       = 0;
    int              rd_ptr       = 0;
    int              xfer_base    = 0;
    int              open_beats   = 0;
    int              xfer_beats   = 0;
    int              bursts       = 0;
    int              beats        = 0;
    int              exp_blocks   = 0;
    int              window_beats = 1;
    sdma_pkg::addr_t exp_addr     = '0;
    logic            window_hold  = 1'b0;
    string           test_name    = "reset";

    always #20 clock = ~clock;

    sdma_engine #(.BURST_BEATS(BURST_BEATS)) dut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Serializer writes an incrementing word stream
    function automatic sdma_pkg::word_t pattern(input int index);
        return 32'hc0de_0000 + sdma_pkg::word_t'(index);
    endfunction

    assign fifo_data = pattern(rd_ptr);

    ////////////////////////////////////////////////////////////////////////////
    // Random ready and credit sources
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        rnd_state = xorshift(rnd_state);
        if (!reset) begin
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            credit   <= 1'b0;
        end else begin
            aw_ready <= rnd_state[1] | rnd_state[2];
            w_ready  <= rnd_state[3] | rnd_state[4];
            credit   <= (rnd_state[5] | rnd_state[6]) && (wr_ptr - rd_ptr < FIFO_CAP);
        end
    end

    // FIFO, address and beat reference model
    always @(posedge clock) begin
        wr_ptr <= wr_ptr + int'(credit);
        if (start) begin
            // New transfer starts from an empty FIFO
            rd_ptr     <= wr_ptr;
            xfer_base  <= wr_ptr;
            xfer_beats <= 0;
            exp_addr   <= start_addr;
        end else begin
            if (fifo_read) begin
                rd_ptr <= rd_ptr + 1;
            end
            if (sys_addr_changed) begin
                exp_addr <= new_addr;
            end else if (aw.valid && aw_ready) begin
                exp_addr <= exp_addr + 32'd64;
            end
        end
        if (aw.valid && aw_ready) begin
            open_beats <= BURST_BEATS;
            bursts     <= bursts + 1;
        end else if (w.valid && w_ready) begin
            open_beats <= open_beats - 1;
            xfer_beats <= xfer_beats + 1;
            beats      <= beats + 1;
        end
        if (abort) begin
            open_beats <= 0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_beat_in_burst: assert property (@(posedge clock) disable iff (!reset)
        w.valid && w_ready |-> open_beats > 0)
        else begin
            errors++;
            $display("Beat accepted outside a burst in %s", test_name);
        end

    a_last: assert property (@(posedge clock) disable iff (!reset)
        w.valid && w_ready |-> w.last == (open_beats == 1))
        else begin
            errors++;
            $display("ERROR %s: last expected %0d, actual %0d", test_name,
                     $sampled(open_beats == 1), $sampled(w.last));
        end

    a_full_burst: assert property (@(posedge clock) disable iff (!reset)
        aw.valid && aw_ready |-> open_beats == 0)
        else begin
            errors++;
            $display("ERROR %s: open beats expected 0, actual %0d", test_name,
                     $sampled(open_beats));
        end

    a_addr: assert property (@(posedge clock) disable iff (!reset)
        aw.valid && aw_ready |-> aw.addr == exp_addr)
        else begin
            errors++;
            $display("ERROR %s: address expected %h, actual %h", test_name,
                     $sampled(exp_addr), $sampled(aw.addr));
        end

    a_fifo_level: assert property (@(posedge clock) disable iff (!reset)
        fifo_read |-> wr_ptr > rd_ptr)
        else begin
            errors++;
            $display("FIFO popped while empty in %s", test_name);
        end

    // Beat n of a transfer carries the n-th word written since start
    a_data: assert property (@(posedge clock) disable iff (!reset)
        w.valid && w_ready |-> w.data == pattern(xfer_base + xfer_beats))
        else begin
            errors++;
            $display("ERROR %s: data expected %h, actual %h", test_name,
                     pattern($sampled(xfer_base + xfer_beats)), $sampled(w.data));
        end

    a_complete: assert property (@(posedge clock) disable iff (!reset)
        $rose(irq.complete) |-> !busy && xfer_beats == exp_blocks * sdma_pkg::BLOCK_WORDS)
        else begin
            errors++;
            $display("ERROR %s: beats at completion expected %0d, actual %0d, busy %0d",
                     test_name, exp_blocks * sdma_pkg::BLOCK_WORDS, $sampled(xfer_beats),
                     $sampled(busy));
        end

    a_quiet_idle: assert property (@(posedge clock) disable iff (!reset)
        !busy |-> !aw.valid && !w.valid)
        else begin
            errors++;
            $display("Valid high while engine idle in %s", test_name);
        end

    a_boundary: assert property (@(posedge clock) disable iff (!reset)
        $rose(irq.boundary) |-> xfer_beats != 0 && xfer_beats % window_beats == 0)
        else begin
            errors++;
            $display("ERROR %s: beats at boundary expected multiple of %0d, actual %0d",
                     test_name, window_beats, $sampled(xfer_beats));
        end

    a_hold: assert property (@(posedge clock) disable iff (!reset)
        window_hold |-> !(aw.valid && aw_ready))
        else begin
            errors++;
            $display("Address accepted in boundary wait in %s", test_name);
        end

    a_irq_clear: assert property (@(posedge clock) disable iff (!reset)
        irq_clear |=> irq == '0)
        else begin
            errors++;
            $display("ERROR %s: irq expected 0, actual %b", test_name, $sampled(irq));
        end

    a_abort: assert property (@(posedge clock) disable iff (!reset)
        abort |=> !aw.valid && !w.valid && !busy)
        else begin
            errors++;
            $display("Engine still active after abort in %s", test_name);
        end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic start_transfer(input string name, input sdma_pkg::addr_t addr,
                                  input int blocks, input sdma_pkg::boundary_code_t code);
        @(posedge clock);
        test_name    = name;
        exp_blocks   = blocks;
        window_beats = (8 << code) * sdma_pkg::BLOCK_WORDS;
        start        <= 1'b1;
        start_addr   <= addr;
        block_count  <= sdma_pkg::block_count_t'(blocks);
        buf_boundary <= code;
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic pulse_irq_clear();
        @(posedge clock);
        irq_clear <= 1'b1;
        @(posedge clock);
        irq_clear <= 1'b0;
    endtask

    task automatic wait_complete();
        while (!irq.complete) begin
            @(posedge clock);
        end
    endtask

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: no completion within %0d cycles in %s", CYCLE_LIMIT, test_name);
            $display("Errors: %0d, bursts: %0d, beats: %0d", errors, bursts, beats);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        reset            <= 1'b0;
        start            <= 1'b0;
        start_addr       <= '0;
        block_count      <= '0;
        buf_boundary     <= '0;
        sys_addr_changed <= 1'b0;
        new_addr         <= '0;
        abort            <= 1'b0;
        irq_clear        <= 1'b0;
        repeat (5) @(posedge clock);
        reset <= 1'b1;
        repeat (2) @(posedge clock);

        start_transfer("three_blocks", 32'h1000_0000, 3, 3'd7);
        wait_complete();
        pulse_irq_clear();

        // Code 0 gives an 8 block window
        start_transfer("boundary_window", 32'h2000_0000, 12, 3'd0);
        while (!irq.boundary) begin
            @(posedge clock);
        end
        window_hold <= 1'b1;
        repeat (30) @(posedge clock);
        window_hold      <= 1'b0;
        sys_addr_changed <= 1'b1;
        new_addr         <= 32'h3000_0000;
        @(posedge clock);
        sys_addr_changed <= 1'b0;
        pulse_irq_clear();
        wait_complete();
        pulse_irq_clear();

        start_transfer("abort", 32'h4000_0000, 2, 3'd7);
        while (!(w.valid && xfer_beats > 20)) begin
            @(posedge clock);
        end
        abort <= 1'b1;
        @(posedge clock);
        abort <= 1'b0;
        repeat (4) @(posedge clock);
        start_transfer("restart", 32'h5000_0000, 1, 3'd7);
        wait_complete();
        pulse_irq_clear();
        repeat (4) @(posedge clock);

        $display("Errors: %0d, bursts: %0d, beats: %0d", errors, bursts, beats);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sdma_engine.f */
source/sdma_pkg.sv
source/sdma_sequencer.sv
source/block_tracker.sv
source/credit_counter.sv
source/burst_writer.sv
source/sdma_engine.sv
verif/sdma_engine_tb.sv
